//--- verilog/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam int DataWidth     = 32;
    localparam int RegAddrWidth  = 5;
    localparam int WordAddrWidth = DataWidth - 2;

    typedef enum logic [5:0] {
        OpRtype = 6'h00,
        OpJ     = 6'h02,
        OpBeq   = 6'h04,
        OpBne   = 6'h05,
        OpAddi  = 6'h08,
        OpLw    = 6'h23,
        OpSw    = 6'h2b
    } opcodeT;

    typedef enum logic [5:0] {
        FnAdd = 6'h20,
        FnSub = 6'h22,
        FnAnd = 6'h24,
        FnOr  = 6'h25,
        FnSlt = 6'h2a
    } functT;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluSlt
    } aluOpT;

    // Source of an execute operand
    typedef enum logic [1:0] {
        FwdReg = 2'd0,
        FwdMem = 2'd1,
        FwdWb  = 2'd2
    } fwdSelT;

    // One instruction word, three field layouts
    typedef union packed {
        struct packed {
            opcodeT                  opcode;
            logic [RegAddrWidth-1:0] rs;
            logic [RegAddrWidth-1:0] rt;
            logic [RegAddrWidth-1:0] rd;
            logic [4:0]              shamt;
            functT                   funct;
        } r;
        struct packed {
            opcodeT                  opcode;
            logic [RegAddrWidth-1:0] rs;
            logic [RegAddrWidth-1:0] rt;
            logic [15:0]             imm;
        } i;
        struct packed {
            opcodeT      opcode;
            logic [25:0] target;
        } j;
    } instWordT;

endpackage

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  mipsPkg::aluOpT                     op_i,
    input  logic [mipsPkg::DataWidth-1:0]      a_i,
    input  logic [mipsPkg::DataWidth-1:0]      b_i,
    output logic [mipsPkg::DataWidth-1:0]      result_o
);
    import mipsPkg::*;

    logic lessThan;

    // Signed compare for slt
    assign lessThan = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            AluAdd:  result_o = a_i + b_i;
            AluSub:  result_o = a_i - b_i;
            AluAnd:  result_o = a_i & b_i;
            AluOr:   result_o = a_i | b_i;
            AluSlt:  result_o = {{(DataWidth-1){1'b0}}, lessThan};
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               we_i,
    input  logic [mipsPkg::RegAddrWidth-1:0]   waddr_i,
    input  logic [mipsPkg::DataWidth-1:0]      wdata_i,
    input  logic [mipsPkg::RegAddrWidth-1:0]   raddrA_i,
    input  logic [mipsPkg::RegAddrWidth-1:0]   raddrB_i,
    output logic [mipsPkg::DataWidth-1:0]      rdataA_o,
    output logic [mipsPkg::DataWidth-1:0]      rdataB_o
);
    import mipsPkg::*;

    logic [DataWidth-1:0] regs [2**RegAddrWidth];
    logic                 writeValid;

    assign writeValid = we_i && (waddr_i != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 2**RegAddrWidth; k++) begin
                regs[k] <= '0;
            end
        end else if (writeValid) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Same-cycle write is visible to decode
    assign rdataA_o = (writeValid && waddr_i == raddrA_i) ? wdata_i : regs[raddrA_i];
    assign rdataB_o = (writeValid && waddr_i == raddrB_i) ? wdata_i : regs[raddrB_i];

    assert property (@(posedge clk) disable iff (rst)
        ((raddrA_i == '0) |-> (rdataA_o == '0)) and ((raddrB_i == '0) |-> (rdataB_o == '0)));

endmodule

`default_nettype wire

//--- verilog/decodeControl.sv
`timescale 1ns/1ps
`default_nettype none

module decodeControl (
    input  mipsPkg::instWordT                  inst_i,
    output mipsPkg::aluOpT                     aluOp_o,
    output logic                               regWrite_o,
    output logic                               memRead_o,
    output logic                               memWrite_o,
    output logic                               aluSrcImm_o,
    output logic                               branchEq_o,
    output logic                               branchNe_o,
    output logic                               jump_o,
    output logic [mipsPkg::RegAddrWidth-1:0]   destReg_o,
    output logic [mipsPkg::DataWidth-1:0]      imm_o
);
    import mipsPkg::*;

    always_comb begin
        aluOp_o     = AluAdd;
        regWrite_o  = 1'b0;
        memRead_o   = 1'b0;
        memWrite_o  = 1'b0;
        aluSrcImm_o = 1'b0;
        branchEq_o  = 1'b0;
        branchNe_o  = 1'b0;
        jump_o      = 1'b0;
        destReg_o   = inst_i.i.rt;
        imm_o       = {{(DataWidth-16){inst_i.i.imm[15]}}, inst_i.i.imm};

        case (inst_i.r.opcode)
            OpRtype: begin
                destReg_o  = inst_i.r.rd;
                regWrite_o = 1'b1;
                case (inst_i.r.funct)
                    FnAdd:   aluOp_o = AluAdd;
                    FnSub:   aluOp_o = AluSub;
                    FnAnd:   aluOp_o = AluAnd;
                    FnOr:    aluOp_o = AluOr;
                    FnSlt:   aluOp_o = AluSlt;
                    // Unsupported funct, including the zero word
                    default: regWrite_o = 1'b0;
                endcase
            end
            OpAddi: begin
                regWrite_o  = 1'b1;
                aluSrcImm_o = 1'b1;
            end
            OpLw: begin
                regWrite_o  = 1'b1;
                memRead_o   = 1'b1;
                aluSrcImm_o = 1'b1;
            end
            OpSw: begin
                memWrite_o  = 1'b1;
                aluSrcImm_o = 1'b1;
            end
            OpBeq: begin
                branchEq_o = 1'b1;
            end
            OpBne: begin
                branchNe_o = 1'b1;
            end
            OpJ: begin
                jump_o = 1'b1;
                imm_o  = {{(DataWidth-28){1'b0}}, inst_i.j.target, 2'b00};
            end
            default: begin
                regWrite_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  logic [mipsPkg::RegAddrWidth-1:0]   decRs_i,
    input  logic [mipsPkg::RegAddrWidth-1:0]   decRt_i,
    input  logic [mipsPkg::RegAddrWidth-1:0]   exRs_i,
    input  logic [mipsPkg::RegAddrWidth-1:0]   exRt_i,
    input  logic [mipsPkg::RegAddrWidth-1:0]   exRd_i,
    input  logic                               exMemRead_i,
    input  logic [mipsPkg::RegAddrWidth-1:0]   memRd_i,
    input  logic                               memRegWrite_i,
    input  logic [mipsPkg::RegAddrWidth-1:0]   wbRd_i,
    input  logic                               wbRegWrite_i,
    input  logic                               redirect_i,
    input  logic                               imemStall_i,
    input  logic                               dmemStall_i,
    output logic                               pcWrite_o,
    output logic                               fetchWrite_o,
    output logic                               fetchFlush_o,
    output logic                               execWrite_o,
    output logic                               execFlush_o,
    output logic                               advance_o,
    output mipsPkg::fwdSelT                    fwdA_o,
    output mipsPkg::fwdSelT                    fwdB_o
);
    import mipsPkg::*;

    logic freeze;
    logic loadUse;
    logic memHitA, memHitB, wbHitA, wbHitB;

    assign freeze  = imemStall_i || dmemStall_i;
    assign loadUse = exMemRead_i && (exRd_i != '0) &&
                     ((exRd_i == decRs_i) || (exRd_i == decRt_i));

    // Redirect never pairs with load-use, a load cannot branch
    assign advance_o    = !freeze;
    assign pcWrite_o    = !freeze && (redirect_i || !loadUse);
    assign fetchWrite_o = !freeze && !loadUse;
    assign fetchFlush_o = !freeze && redirect_i;
    assign execWrite_o  = !freeze;
    assign execFlush_o  = !freeze && (redirect_i || loadUse);

    // Memory stage is the younger writer
    assign memHitA = memRegWrite_i && (memRd_i != '0) && (memRd_i == exRs_i);
    assign memHitB = memRegWrite_i && (memRd_i != '0) && (memRd_i == exRt_i);
    assign wbHitA  = wbRegWrite_i && (wbRd_i != '0) && (wbRd_i == exRs_i);
    assign wbHitB  = wbRegWrite_i && (wbRd_i != '0) && (wbRd_i == exRt_i);

    assign fwdA_o = memHitA ? FwdMem : (wbHitA ? FwdWb : FwdReg);
    assign fwdB_o = memHitB ? FwdMem : (wbHitB ? FwdWb : FwdReg);

endmodule

`default_nettype wire

//--- verilog/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
    parameter logic [mipsPkg::DataWidth-1:0] ResetPc = '0
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               pcWrite_i,
    input  logic                               fetchWrite_i,
    input  logic                               fetchFlush_i,
    input  logic                               redirect_i,
    input  logic [mipsPkg::DataWidth-1:0]      redirectPc_i,
    input  logic [mipsPkg::DataWidth-1:0]      imemData_i,
    output logic [mipsPkg::WordAddrWidth-1:0]  imemAddr_o,
    output mipsPkg::instWordT                  inst_o,
    output logic [mipsPkg::DataWidth-1:0]      pcPlus4_o
);
    import mipsPkg::*;

    logic [DataWidth-1:0] pc;
    logic [DataWidth-1:0] pcPlus4;

    assign pcPlus4    = pc + DataWidth'(4);
    assign imemAddr_o = pc[DataWidth-1:2];

    // Resolved branch or jump wins over sequential fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= ResetPc;
        end else if (pcWrite_i) begin
            pc <= redirect_i ? redirectPc_i : pcPlus4;
        end
    end

    // All-zero word decodes as a no-op
    always_ff @(posedge clk) begin
        if (rst || fetchFlush_i) begin
            inst_o <= '0;
        end else if (fetchWrite_i) begin
            inst_o <= imemData_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchWrite_i) begin
            pcPlus4_o <= pcPlus4;
        end
    end

endmodule

`default_nettype wire

//--- verilog/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               execWrite_i,
    input  logic                               execFlush_i,
    input  logic                               advance_i,
    input  mipsPkg::aluOpT                     aluOp_i,
    input  logic                               regWrite_i,
    input  logic                               memRead_i,
    input  logic                               memWrite_i,
    input  logic                               aluSrcImm_i,
    input  logic                               branchEq_i,
    input  logic                               branchNe_i,
    input  logic                               jump_i,
    input  logic [mipsPkg::RegAddrWidth-1:0]   decRs_i,
    input  logic [mipsPkg::RegAddrWidth-1:0]   decRt_i,
    input  logic [mipsPkg::RegAddrWidth-1:0]   destReg_i,
    input  logic [mipsPkg::DataWidth-1:0]      rsData_i,
    input  logic [mipsPkg::DataWidth-1:0]      rtData_i,
    input  logic [mipsPkg::DataWidth-1:0]      imm_i,
    input  logic [mipsPkg::DataWidth-1:0]      pcPlus4_i,
    input  mipsPkg::fwdSelT                    fwdA_i,
    input  mipsPkg::fwdSelT                    fwdB_i,
    input  logic [mipsPkg::DataWidth-1:0]      memFwd_i,
    input  logic [mipsPkg::DataWidth-1:0]      wbFwd_i,
    output logic [mipsPkg::RegAddrWidth-1:0]   exRs_o,
    output logic [mipsPkg::RegAddrWidth-1:0]   exRt_o,
    output logic [mipsPkg::RegAddrWidth-1:0]   exRd_o,
    output logic                               exMemRead_o,
    output logic                               redirect_o,
    output logic [mipsPkg::DataWidth-1:0]      redirectPc_o,
    output logic                               memRegWrite_o,
    output logic                               memRead_o,
    output logic                               memWrite_o,
    output logic [mipsPkg::RegAddrWidth-1:0]   memRd_o,
    output logic [mipsPkg::DataWidth-1:0]      aluRes_o,
    output logic [mipsPkg::DataWidth-1:0]      storeData_o
);
    import mipsPkg::*;

    aluOpT exAluOp;
    logic exRegWrite, exMemWrite, exAluSrcImm;
    logic exBranchEq, exBranchNe, exJump;
    logic [DataWidth-1:0] exRsData, exRtData, exImm, exPcPlus4;
    logic [DataWidth-1:0] rsFwd, rtFwd, opB, aluOut;
    logic taken;

    function automatic logic [DataWidth-1:0] fwdMux(
        input fwdSelT               sel,
        input logic [DataWidth-1:0] regVal,
        input logic [DataWidth-1:0] memVal,
        input logic [DataWidth-1:0] wbVal
    );
        case (sel)
            FwdMem:  return memVal;
            FwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    // Decode/execute register, a flush leaves a bubble
    always_ff @(posedge clk) begin
        if (rst || execFlush_i) begin
            exRegWrite  <= 1'b0;
            exMemRead_o <= 1'b0;
            exMemWrite  <= 1'b0;
            exBranchEq  <= 1'b0;
            exBranchNe  <= 1'b0;
            exJump      <= 1'b0;
        end else if (execWrite_i) begin
            exRegWrite  <= regWrite_i;
            exMemRead_o <= memRead_i;
            exMemWrite  <= memWrite_i;
            exBranchEq  <= branchEq_i;
            exBranchNe  <= branchNe_i;
            exJump      <= jump_i;
        end
    end

    always_ff @(posedge clk) begin
        if (execWrite_i) begin
            exAluOp     <= aluOp_i;
            exAluSrcImm <= aluSrcImm_i;
            exRs_o      <= decRs_i;
            exRt_o      <= decRt_i;
            exRd_o      <= destReg_i;
            exRsData    <= rsData_i;
            exRtData    <= rtData_i;
            exImm       <= imm_i;
            exPcPlus4   <= pcPlus4_i;
        end
    end

    assign rsFwd = fwdMux(fwdA_i, exRsData, memFwd_i, wbFwd_i);
    assign rtFwd = fwdMux(fwdB_i, exRtData, memFwd_i, wbFwd_i);
    assign opB   = exAluSrcImm ? exImm : rtFwd;

    alu alu0 (
        .op_i     (exAluOp),
        .a_i      (rsFwd),
        .b_i      (opB),
        .result_o (aluOut)
    );

    assign taken        = (exBranchEq && (rsFwd == rtFwd)) || (exBranchNe && (rsFwd != rtFwd));
    assign redirect_o   = taken || exJump;
    // Jump keeps the upper four PC bits
    assign redirectPc_o = exJump ? {exPcPlus4[DataWidth-1:28], exImm[27:0]}
                                 : exPcPlus4 + {exImm[DataWidth-3:0], 2'b00};

    // Execute/memory register
    always_ff @(posedge clk) begin
        if (rst) begin
            memRegWrite_o <= 1'b0;
            memRead_o     <= 1'b0;
            memWrite_o    <= 1'b0;
        end else if (advance_i) begin
            memRegWrite_o <= exRegWrite;
            memRead_o     <= exMemRead_o;
            memWrite_o    <= exMemWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            memRd_o     <= exRd_o;
            aluRes_o    <= aluOut;
            storeData_o <= rtFwd;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mipsPipeline.sv
`timescale 1ns/1ps
`default_nettype none

module mipsPipeline #(
    parameter logic [mipsPkg::DataWidth-1:0] ResetPc = '0
) (
    input  logic                               clk,
    input  logic                               rst,
    output logic [mipsPkg::WordAddrWidth-1:0]  imemAddr_o,
    input  logic [mipsPkg::DataWidth-1:0]      imemData_i,
    input  logic                               imemStall_i,
    output logic                               dmemRen_o,
    output logic                               dmemWen_o,
    output logic [mipsPkg::WordAddrWidth-1:0]  dmemAddr_o,
    output logic [mipsPkg::DataWidth-1:0]      dmemWdata_o,
    input  logic [mipsPkg::DataWidth-1:0]      dmemRdata_i,
    input  logic                               dmemStall_i
);
    import mipsPkg::*;

    // Stage enables
    logic pcWrite, fetchWrite, fetchFlush;
    logic execWrite, execFlush, advance;
    fwdSelT fwdA, fwdB;

    // Decode
    instWordT decInst;
    logic [DataWidth-1:0] decPcPlus4, decImm, rsData, rtData;
    logic [RegAddrWidth-1:0] decDest;
    aluOpT decAluOp;
    logic decRegWrite, decMemRead, decMemWrite, decAluSrcImm;
    logic decBranchEq, decBranchNe, decJump;

    // Execute
    logic redirect;
    logic [DataWidth-1:0] redirectPc;
    logic [RegAddrWidth-1:0] exRs, exRt, exRd;
    logic exMemRead;

    // Memory
    logic memRegWrite, memRead, memWrite;
    logic [RegAddrWidth-1:0] memRd;
    logic [DataWidth-1:0] memAluRes, memStoreData;

    // Writeback
    logic wbRegWrite, wbMemToReg;
    logic [RegAddrWidth-1:0] wbRd;
    logic [DataWidth-1:0] wbLoadData, wbAluRes, wbData;

    fetchStage #(
        .ResetPc(ResetPc)
    ) fetch0 (
        .clk          (clk),
        .rst          (rst),
        .pcWrite_i    (pcWrite),
        .fetchWrite_i (fetchWrite),
        .fetchFlush_i (fetchFlush),
        .redirect_i   (redirect),
        .redirectPc_i (redirectPc),
        .imemData_i   (imemData_i),
        .imemAddr_o   (imemAddr_o),
        .inst_o       (decInst),
        .pcPlus4_o    (decPcPlus4)
    );

    decodeControl decode0 (
        .inst_i      (decInst),
        .aluOp_o     (decAluOp),
        .regWrite_o  (decRegWrite),
        .memRead_o   (decMemRead),
        .memWrite_o  (decMemWrite),
        .aluSrcImm_o (decAluSrcImm),
        .branchEq_o  (decBranchEq),
        .branchNe_o  (decBranchNe),
        .jump_o      (decJump),
        .destReg_o   (decDest),
        .imm_o       (decImm)
    );

    // Writes wait for the freeze to end
    regFile regs0 (
        .clk      (clk),
        .rst      (rst),
        .we_i     (wbRegWrite && advance),
        .waddr_i  (wbRd),
        .wdata_i  (wbData),
        .raddrA_i (decInst.r.rs),
        .raddrB_i (decInst.r.rt),
        .rdataA_o (rsData),
        .rdataB_o (rtData)
    );

    hazardUnit hazard0 (
        .decRs_i       (decInst.r.rs),
        .decRt_i       (decInst.r.rt),
        .exRs_i        (exRs),
        .exRt_i        (exRt),
        .exRd_i        (exRd),
        .exMemRead_i   (exMemRead),
        .memRd_i       (memRd),
        .memRegWrite_i (memRegWrite),
        .wbRd_i        (wbRd),
        .wbRegWrite_i  (wbRegWrite),
        .redirect_i    (redirect),
        .imemStall_i   (imemStall_i),
        .dmemStall_i   (dmemStall_i),
        .pcWrite_o     (pcWrite),
        .fetchWrite_o  (fetchWrite),
        .fetchFlush_o  (fetchFlush),
        .execWrite_o   (execWrite),
        .execFlush_o   (execFlush),
        .advance_o     (advance),
        .fwdA_o        (fwdA),
        .fwdB_o        (fwdB)
    );

    executeStage execute0 (
        .clk           (clk),
        .rst           (rst),
        .execWrite_i   (execWrite),
        .execFlush_i   (execFlush),
        .advance_i     (advance),
        .aluOp_i       (decAluOp),
        .regWrite_i    (decRegWrite),
        .memRead_i     (decMemRead),
        .memWrite_i    (decMemWrite),
        .aluSrcImm_i   (decAluSrcImm),
        .branchEq_i    (decBranchEq),
        .branchNe_i    (decBranchNe),
        .jump_i        (decJump),
        .decRs_i       (decInst.r.rs),
        .decRt_i       (decInst.r.rt),
        .destReg_i     (decDest),
        .rsData_i      (rsData),
        .rtData_i      (rtData),
        .imm_i         (decImm),
        .pcPlus4_i     (decPcPlus4),
        .fwdA_i        (fwdA),
        .fwdB_i        (fwdB),
        .memFwd_i      (memAluRes),
        .wbFwd_i       (wbData),
        .exRs_o        (exRs),
        .exRt_o        (exRt),
        .exRd_o        (exRd),
        .exMemRead_o   (exMemRead),
        .redirect_o    (redirect),
        .redirectPc_o  (redirectPc),
        .memRegWrite_o (memRegWrite),
        .memRead_o     (memRead),
        .memWrite_o    (memWrite),
        .memRd_o       (memRd),
        .aluRes_o      (memAluRes),
        .storeData_o   (memStoreData)
    );

    assign dmemRen_o   = memRead;
    // A store waits out a fetch stall so the frozen slot is not written twice
    assign dmemWen_o   = memWrite && !imemStall_i;
    assign dmemAddr_o  = memAluRes[DataWidth-1:2];
    assign dmemWdata_o = memStoreData;

    // Memory/writeback register
    always_ff @(posedge clk) begin
        if (rst) begin
            wbRegWrite <= 1'b0;
        end else if (advance) begin
            wbRegWrite <= memRegWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            wbMemToReg <= memRead;
            wbRd       <= memRd;
            wbLoadData <= dmemRdata_i;
            wbAluRes   <= memAluRes;
        end
    end

    assign wbData = wbMemToReg ? wbLoadData : wbAluRes;

    // Fetch address holds across an instruction stall
    assert property (@(posedge clk) disable iff (rst)
        imemStall_i |=> $stable(imemAddr_o));

    // A freeze leaves the decode instruction and the data port untouched
    assert property (@(posedge clk) disable iff (rst)
        (imemStall_i || dmemStall_i) |=>
            $stable(decInst) && $stable({memRead, memWrite, dmemAddr_o, dmemWdata_o}));

endmodule

`default_nettype wire

//--- tb/tbMemory.sv
`timescale 1ns/1ps
`default_nettype none

module tbMemory #(
    parameter int Depth    = 256,
    parameter int StallPct = 25,
    parameter int Seed     = 11900,
    parameter int Tap      = 16
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               stallEn_i,
    input  logic [mipsPkg::WordAddrWidth-1:0]  addr_i,
    input  logic                               wen_i,
    input  logic [mipsPkg::DataWidth-1:0]      wdata_i,
    output logic [mipsPkg::DataWidth-1:0]      rdata_o,
    output logic                               stall_o
);
    import mipsPkg::*;

    localparam int IdxWidth  = $clog2(Depth);
    localparam int Threshold = (StallPct * 256) / 100;

    logic [DataWidth-1:0] mem [Depth];
    logic [31:0]          lcgState;
    logic                 stallNext;

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        lcgState = Seed;
        stall_o  = 1'b0;
    end

    // Store taken on the edge, new stall driven shortly after it
    always @(posedge clk) begin
        if (wen_i && !stall_o) begin
            mem[addr_i[IdxWidth-1:0]] = wdata_i;
        end
        lcgState  = lcgNext(lcgState);
        stallNext = stallEn_i && !rst && (lcgState[Tap +: 8] < Threshold);
        #2;
        stall_o = stallNext;
    end

    // Nothing valid while stalled
    assign rdata_o = stall_o ? 'x : mem[addr_i[IdxWidth-1:0]];

endmodule

`default_nettype wire

//--- tb/mipsPipelineTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsPipelineTb;
    import mipsPkg::*;

    localparam logic [DataWidth-1:0] ResetPc = 32'h0000_0000;
    localparam int MemDepth       = 256;
    localparam int StallPct       = 25;
    localparam int TimeoutPerWord = 40;
    localparam int TimeoutBase    = 200;
    localparam int ResetCycles    = 8;
    localparam int DrainCycles    = 30;
    localparam int TestWords      = 1024;
    localparam int DataBase       = 'h100;
    localparam int StoreBase      = 'h200;

    logic                     clk;
    logic                     rst;
    logic                     stallEn;
    logic [WordAddrWidth-1:0] imemAddr;
    logic [DataWidth-1:0]     imemData;
    logic                     imemStall;
    logic                     dmemRen;
    logic                     dmemWen;
    logic [WordAddrWidth-1:0] dmemAddr;
    logic [DataWidth-1:0]     dmemWdata;
    logic [DataWidth-1:0]     dmemRdata;
    logic                     dmemStall;

    logic [DataWidth-1:0] testData [TestWords];
    int   progWords;
    int   dataWords;
    int   expCount;
    int   storeIdx;
    int   storesChecked;
    int   errors;
    int   cycleCount;
    int   cycleLimit;
    int   runIdx;
    logic running;

    mipsPipeline #(
        .ResetPc(ResetPc)
    ) dut0 (
        .clk         (clk),
        .rst         (rst),
        .imemAddr_o  (imemAddr),
        .imemData_i  (imemData),
        .imemStall_i (imemStall),
        .dmemRen_o   (dmemRen),
        .dmemWen_o   (dmemWen),
        .dmemAddr_o  (dmemAddr),
        .dmemWdata_o (dmemWdata),
        .dmemRdata_i (dmemRdata),
        .dmemStall_i (dmemStall)
    );

    tbMemory #(.Depth(MemDepth), .StallPct(StallPct), .Tap(16)) imem0 (
        .clk       (clk),
        .rst       (rst),
        .stallEn_i (stallEn),
        .addr_i    (imemAddr),
        .wen_i     (1'b0),
        .wdata_i   ('0),
        .rdata_o   (imemData),
        .stall_o   (imemStall)
    );

    tbMemory #(.Depth(MemDepth), .StallPct(StallPct), .Tap(24)) dmem0 (
        .clk       (clk),
        .rst       (rst),
        .stallEn_i (stallEn),
        .addr_i    (dmemAddr),
        .wen_i     (dmemWen),
        .wdata_i   (dmemWdata),
        .rdata_o   (dmemRdata),
        .stall_o   (dmemStall)
    );

    always #10 clk = ~clk;

    // Number of words up to the last defined one in a region
    function automatic int countWords(input int base, input int span);
        int last;
        last = 0;
        for (int k = 0; k < span; k++) begin
            if (!$isunknown(testData[base + k])) begin
                last = k + 1;
            end
        end
        return last;
    endfunction

    task automatic loadMemories();
        for (int k = 0; k < MemDepth; k++) begin
            // Zero words past the program decode as no-ops
            imem0.mem[k] = (k < progWords) ? testData[k] : '0;
            dmem0.mem[k] = (k < dataWords) ? testData[DataBase + k] : (32'hD0D0_0000 | k);
        end
    endtask

    task automatic checkStore();
        logic [DataWidth-1:0] expAddr;
        logic [DataWidth-1:0] expData;
        logic [DataWidth-1:0] gotAddr;
        gotAddr = {dmemAddr, 2'b00};
        if (storeIdx >= expCount) begin
            $display("Extra store in run %0d at %0t: address %h data %h after all %0d expected",
                     runIdx, $time, gotAddr, dmemWdata, expCount);
            errors = errors + 1;
        end else begin
            expAddr = testData[StoreBase + 1 + 2 * storeIdx];
            expData = testData[StoreBase + 2 + 2 * storeIdx];
            if (gotAddr !== expAddr) begin
                $display("CHECK FAILED at %0t: run %0d store %0d address %h, expected %h",
                         $time, runIdx, storeIdx, gotAddr, expAddr);
                errors = errors + 1;
            end
            if (dmemWdata !== expData) begin
                $display("CHECK FAILED at %0t: run %0d store %0d data %h, expected %h",
                         $time, runIdx, storeIdx, dmemWdata, expData);
                errors = errors + 1;
            end
        end
        storeIdx      = storeIdx + 1;
        storesChecked = storesChecked + 1;
    endtask

    // First fetch at ResetPc, no data access before a load or store reaches memory
    task automatic checkStartup();
        @(negedge clk);
        if (imemAddr !== ResetPc[DataWidth-1:2]) begin
            $display("CHECK FAILED at %0t: run %0d first fetch address %h, expected %h",
                     $time, runIdx, imemAddr, ResetPc[DataWidth-1:2]);
            errors = errors + 1;
        end
        for (int k = 0; k < 3; k++) begin
            if (k > 0) begin
                @(negedge clk);
            end
            if (dmemRen !== 1'b0 || dmemWen !== 1'b0) begin
                $display("CHECK FAILED at %0t: run %0d data access %b%b right after reset",
                         $time, runIdx, dmemRen, dmemWen);
                errors = errors + 1;
            end
        end
    endtask

    task automatic runProgram(input logic withStalls);
        @(posedge clk);
        #2;
        rst     = 1'b1;
        running = 1'b0;
        stallEn = withStalls;
        @(posedge clk);
        loadMemories();
        storeIdx   = 0;
        cycleCount = 0;
        repeat (ResetCycles - 1) @(posedge clk);
        #2;
        rst     = 1'b0;
        running = 1'b1;
        checkStartup();
        wait (storeIdx == expCount);
        // Room for a stray store to show up
        repeat (DrainCycles) @(posedge clk);
        #2;
        running = 1'b0;
        runIdx  = runIdx + 1;
    endtask

    // Store condition here holds up to the next rising edge
    always @(negedge clk) begin
        if (running) begin
            cycleCount = cycleCount + 1;
            if (dmemWen === 1'b1 && dmemStall === 1'b0) begin
                checkStore();
            end
            if (cycleCount > cycleLimit) begin
                $display("Timeout in run %0d: %0d of %0d expected stores seen in %0d cycles",
                         runIdx, storeIdx, expCount, cycleLimit);
                errors = errors + 1;
                $display("Stores checked: %0d, errors: %0d", storesChecked, errors);
                $display("Finished with errors");
                $finish;
            end
        end
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        stallEn       = 1'b0;
        running       = 1'b0;
        errors        = 0;
        storesChecked = 0;
        storeIdx      = 0;
        cycleCount    = 0;
        runIdx        = 0;
        $readmemh("tb/testdata.txt", testData);
        progWords  = countWords(0, DataBase);
        dataWords  = countWords(DataBase, StoreBase - DataBase);
        expCount   = testData[StoreBase];
        cycleLimit = TimeoutPerWord * progWords + TimeoutBase;

        runProgram(1'b0);
        runProgram(1'b1);

        $display("Stores checked: %0d, errors: %0d", storesChecked, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/testdata.txt
// Columns: 32-bit hex words, several per line; @ lines set the array index
// 000 program words, 100 data memory words, 200 store count then byte address/data pairs
@000
8C010000 8C020004 00221820 AC030040  // lw $1, lw $2, add $3 (load-use), sw $3
00222022 00812824 00A43025 AC040044  // sub $4, and $5, or $6, sw $4
AC050048 AC06004C 0041382A 0022402A  // sw $5, sw $6, slt $7, slt $8
20E9FFFB AC070050 AC080054 AC090058  // addi $9, sw $7, sw $8, sw $9
20200005 AC00005C 10210002 AC010060  // addi $0, sw $0, beq taken, skipped sw
AC020064 14210001 AC010068 14220001  // skipped sw, bne not taken, sw $1, bne taken
AC02006C 10220001 AC030070 0800001D  // skipped sw, beq not taken, sw $3, j 29
AC010074 8C0A0008 8C0B000C 014B6024  // skipped sw, lw $10, lw $11, and $12 (load-use)
014B6825 018D7022 AC0C0078 AC0D007C  // or $13, sub $14, sw $12, sw $13
AC0E0080 8C0F0040 AC0F0084 08000027  // sw $14, lw $15, sw $15 (load-use), j self
@100
00000007 FFFFFFFD 0000F0F0 00000FF0
@200
0000000E
00000040 00000004
00000044 0000000A
00000048 00000002
0000004C 0000000A
00000050 00000001
00000054 00000000
00000058 FFFFFFFC
0000005C 00000000
00000068 00000007
00000070 00000004
00000078 000000F0
0000007C 0000FFF0
00000080 FFFF0100
00000084 00000004

//--- compile.f
verilog/mipsPkg.sv
verilog/alu.sv
verilog/regFile.sv
verilog/decodeControl.sv
verilog/hazardUnit.sv
verilog/fetchStage.sv
verilog/executeStage.sv
verilog/mipsPipeline.sv
tb/tbMemory.sv
tb/mipsPipelineTb.sv
